/* design/audio_pkg.sv */
// Shared widths, I2S timing and types for the PSG audio output path.
// All logic assumes one clock domain, clk_sys.
// The I2S bit clock is derived from clk_sys and is not a true clock net.

package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// One PSG tone channel, unsigned
	localparam int PSG_CH_W = 12;

	// One output sample per side
	localparam int SAMPLE_W = 16;

	//////////////////////////////////////////////////////////////////////
	// I2S timing
	//////////////////////////////////////////////////////////////////////

	// clk_sys cycles per half bit clock, so bck = clk_sys/8
	localparam int I2S_HALF_BCK = 4;

	// Bit clocks per stereo frame, one 16-bit word per side
	localparam int I2S_FRAME_BITS = 32;

	// Counter widths derived from the timing above
	localparam int I2S_DIV_W = $clog2(I2S_HALF_BCK);
	localparam int I2S_BIT_W = $clog2(I2S_FRAME_BITS);

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// Code 3 is not named and mixes as ACB
	typedef enum logic [1:0] {
		STEREO_MONO = 2'd0,
		STEREO_ABC  = 2'd1,
		STEREO_ACB  = 2'd2
	} stereo_mode_t;

	typedef struct packed {
		logic [PSG_CH_W-1:0] ch_a;
		logic [PSG_CH_W-1:0] ch_b;
		logic [PSG_CH_W-1:0] ch_c;
	} psg_channels_t;

	typedef struct packed {
		logic [SAMPLE_W-1:0] left;
		logic [SAMPLE_W-1:0] right;
	} stereo_sample_t;

endpackage

/* design/psg_stereo_mixer.sv */
// Mixes three unsigned PSG channels into a stereo pair of 16-bit samples.
// Two register stages, so inputs show on sample_o two edges later.
// Mode code 3 is treated as ACB.

`timescale 1ns/100ps

module psg_stereo_mixer (
	input  logic                       clk_sys,
	input  logic                       reset_i,
	input  audio_pkg::psg_channels_t   psg_i,
	input  audio_pkg::stereo_mode_t    stereo_mode_i,
	output audio_pkg::stereo_sample_t  sample_o
);

	// Input stage
	audio_pkg::psg_channels_t psg_q;
	audio_pkg::stereo_mode_t  mode_q;

	// Unsigned sums, one bit of growth per pair and two for all three
	logic [audio_pkg::PSG_CH_W:0]   sum_ab;
	logic [audio_pkg::PSG_CH_W:0]   sum_ac;
	logic [audio_pkg::PSG_CH_W:0]   sum_bc;
	logic [audio_pkg::PSG_CH_W+1:0] sum_abc;

	audio_pkg::stereo_sample_t mix_d;

	//////////////////////////////////////////////////////////////////////
	// Stage 1, register channels and mode
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			psg_q  <= '0;
			mode_q <= audio_pkg::STEREO_MONO;
		end else begin
			psg_q  <= psg_i;
			mode_q <= stereo_mode_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sums and mode select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sum_ab  = {1'b0, psg_q.ch_a} + {1'b0, psg_q.ch_b};
		sum_ac  = {1'b0, psg_q.ch_a} + {1'b0, psg_q.ch_c};
		sum_bc  = {1'b0, psg_q.ch_b} + {1'b0, psg_q.ch_c};
		sum_abc = {2'b00, psg_q.ch_a} + {2'b00, psg_q.ch_b} + {2'b00, psg_q.ch_c};
	end

	// Scale each sum up to full sample width
	always_comb begin
		case (mode_q)
			audio_pkg::STEREO_MONO: begin
				mix_d.left  = {sum_abc, 2'b00};
				mix_d.right = {sum_abc, 2'b00};
			end
			audio_pkg::STEREO_ABC: begin
				mix_d.left  = {sum_ab, 3'b000};
				mix_d.right = {sum_bc, 3'b000};
			end
			default: begin
				// ACB, also taken for code 3
				mix_d.left  = {sum_ac, 3'b000};
				mix_d.right = {sum_bc, 3'b000};
			end
		endcase
	end

	// Stage 2, register the stereo sample
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			sample_o <= '0;
		end else begin
			sample_o <= mix_d;
		end
	end

endmodule

/* design/sigma_delta_dac.sv */
// First-order sigma-delta DAC for one unsigned 16-bit sample.
// The output bit needs an external RC low-pass filter.
// Pulse density is sample/65536, so full scale never reaches all ones.

`timescale 1ns/100ps

module sigma_delta_dac (
	input  logic                          clk_sys,
	input  logic                          reset_i,
	input  logic [audio_pkg::SAMPLE_W-1:0] sample_i,
	output logic                          dac_o
);

	// Low part of the accumulator, carry goes out as the DAC bit
	logic [audio_pkg::SAMPLE_W-1:0] acc_q;
	logic [audio_pkg::SAMPLE_W:0]   acc_sum;

	always_comb begin
		acc_sum = {1'b0, acc_q} + {1'b0, sample_i};
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			acc_q <= '0;
			dac_o <= 1'b0;
		end else begin
			acc_q <= acc_sum[audio_pkg::SAMPLE_W-1:0];
			// Carry out of the add is the pulse
			dac_o <= acc_sum[audio_pkg::SAMPLE_W];
		end
	end

endmodule

/* design/i2s_serializer.sv */
// I2S transmitter, 16 bits per side, bit clock is clk_sys/8.
// Data and lrck change on the falling bit clock; sample on the rising one.
// A frame is latched when lrck goes low and sent with the sign bit inverted.
// The clocks run free from reset; there is no enable.

`timescale 1ns/100ps

module i2s_serializer (
	input  logic                      clk_sys,
	input  logic                      reset_i,
	input  audio_pkg::stereo_sample_t sample_i,
	output logic                      bck_o,
	output logic                      lrck_o,
	output logic                      data_o
);

	// Bit clock divider
	logic [audio_pkg::I2S_DIV_W-1:0] div_cnt;
	logic                            div_last;
	logic                            bck_fall;

	// Position within the frame, counted on falling bit clocks
	logic [audio_pkg::I2S_BIT_W-1:0] bit_cnt;
	logic                            frame_start;

	// Frame shift register, left word in the upper half
	audio_pkg::stereo_sample_t frame_in;
	logic [audio_pkg::I2S_FRAME_BITS-1:0] shift_q;

	//////////////////////////////////////////////////////////////////////
	// Bit clock
	//////////////////////////////////////////////////////////////////////

	assign div_last = (div_cnt == audio_pkg::I2S_DIV_W'(audio_pkg::I2S_HALF_BCK - 1));

	// Next toggle takes bck from high to low
	assign bck_fall = div_last && bck_o;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			div_cnt <= '0;
			bck_o   <= 1'b0;
		end else if (div_last) begin
			div_cnt <= '0;
			bck_o   <= ~bck_o;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Framing
	//////////////////////////////////////////////////////////////////////

	// Left word starts on the first falling edge after reset
	assign frame_start = (bit_cnt == '0);

	// Offset binary to two's complement by flipping the MSB
	always_comb begin
		frame_in.left  = {~sample_i.left[audio_pkg::SAMPLE_W-1],
			sample_i.left[audio_pkg::SAMPLE_W-2:0]};
		frame_in.right = {~sample_i.right[audio_pkg::SAMPLE_W-1],
			sample_i.right[audio_pkg::SAMPLE_W-2:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			bit_cnt <= '0;
			lrck_o  <= 1'b0;
			data_o  <= 1'b0;
			shift_q <= '0;
		end else if (bck_fall) begin
			bit_cnt <= bit_cnt + 1'b1;
			// High for the second half, so it leads each MSB by one bit
			lrck_o  <= (bit_cnt >= audio_pkg::I2S_BIT_W'(audio_pkg::I2S_FRAME_BITS / 2));
			// Last bit of the previous frame goes out with the new load
			data_o  <= shift_q[audio_pkg::I2S_FRAME_BITS-1];
			if (frame_start) begin
				shift_q <= frame_in;
			end else begin
				shift_q <= {shift_q[audio_pkg::I2S_FRAME_BITS-2:0], 1'b0};
			end
		end
	end

endmodule

/* design/psg_audio_out.sv */
// Audio output path: PSG stereo mixer, two sigma-delta DACs and I2S.
// Inputs are plain levels in the clk_sys domain; no handshake.
// Reset is synchronous and clears every output to low.

`timescale 1ns/100ps

module psg_audio_out (
	input  logic                     clk_sys,
	input  logic                     reset_i,
	input  audio_pkg::psg_channels_t psg_i,
	input  audio_pkg::stereo_mode_t  stereo_mode_i,
	output logic                     audio_l_o,
	output logic                     audio_r_o,
	output logic                     i2s_bck_o,
	output logic                     i2s_lrck_o,
	output logic                     i2s_data_o
);

	// Mixed stereo sample shared by the DACs and the I2S side
	audio_pkg::stereo_sample_t mix_sample;

	//////////////////////////////////////////////////////////////////////
	// Mixer
	//////////////////////////////////////////////////////////////////////

	psg_stereo_mixer i_mixer (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.psg_i         (psg_i),
		.stereo_mode_i (stereo_mode_i),
		.sample_o      (mix_sample)
	);

	//////////////////////////////////////////////////////////////////////
	// One-bit DACs
	//////////////////////////////////////////////////////////////////////

	sigma_delta_dac i_dac_l (
		.clk_sys  (clk_sys),
		.reset_i  (reset_i),
		.sample_i (mix_sample.left),
		.dac_o    (audio_l_o)
	);

	sigma_delta_dac i_dac_r (
		.clk_sys  (clk_sys),
		.reset_i  (reset_i),
		.sample_i (mix_sample.right),
		.dac_o    (audio_r_o)
	);

	// I2S stream
	i2s_serializer i_i2s (
		.clk_sys  (clk_sys),
		.reset_i  (reset_i),
		.sample_i (mix_sample),
		.bck_o    (i2s_bck_o),
		.lrck_o   (i2s_lrck_o),
		.data_o   (i2s_data_o)
	);

endmodule

/* verification/psg_audio_out_tb.sv */
// Testbench for the PSG audio output path, seeded random stimulus.
// Expected samples come from a mixing model with the mixer's two-edge delay.
// The I2S decoder samples on the rising bit clock and skips the first frame.

`timescale 1ns/100ps

module psg_audio_out_tb;

	localparam int CLK_PERIOD    = 40;
	localparam int SW            = audio_pkg::SAMPLE_W;
	localparam int FRAME_CYCLES  = audio_pkg::I2S_FRAME_BITS * 2 * audio_pkg::I2S_HALF_BCK;
	localparam int HOLD_FRAMES   = 3;
	localparam int MONO_TRIALS   = 4;
	localparam int PAIR_TRIALS   = 3;
	localparam int CORNER_SETS   = 4;
	localparam int DAC_TRIALS    = 4;
	localparam int DAC_WINDOW    = 4096;
	localparam int DAC_FRAMES    = (DAC_WINDOW + 4) / FRAME_CYCLES + 1;
	localparam int CHANGE_TRIALS = 8;
	localparam int TOTAL_FRAMES  = 2 + MONO_TRIALS * HOLD_FRAMES
		+ 3 * PAIR_TRIALS * HOLD_FRAMES + CORNER_SETS * HOLD_FRAMES
		+ DAC_TRIALS * DAC_FRAMES + CHANGE_TRIALS * 3 + 2;
	localparam int MARGIN_FRAMES = 20;
	localparam longint TIMEOUT_NS =
		longint'(TOTAL_FRAMES + MARGIN_FRAMES) * FRAME_CYCLES * CLK_PERIOD;

	logic                     clk_sys;
	logic                     reset_i;
	audio_pkg::psg_channels_t psg;
	audio_pkg::stereo_mode_t  stereo_mode;
	logic [1:0]               mode_code;
	logic                     audio_l_o;
	logic                     audio_r_o;
	logic                     i2s_bck_o;
	logic                     i2s_lrck_o;
	logic                     i2s_data_o;

	integer seed;
	int     check_count;
	int     error_count;
	int     test_count;
	int     test_checks0;
	int     test_errors0;
	string  test_name;

	// Model pipeline, index k holds the expectation from k edges ago
	audio_pkg::stereo_sample_t exp_hist [0:2];
	audio_pkg::stereo_sample_t exp_q [$];
	logic                      lrck_last;

	// I2S decoder state
	logic          lrck_seen;
	logic          synced;
	int            word_bits;
	int            frame_count;
	logic [SW-1:0] word_sr;
	logic [SW-1:0] left_raw;
	logic [SW-1:0] last_left_raw;
	logic [SW-1:0] last_right_raw;

	psg_audio_out i_dut (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.psg_i         (psg),
		.stereo_mode_i (stereo_mode),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o),
		.i2s_bck_o     (i2s_bck_o),
		.i2s_lrck_o    (i2s_lrck_o),
		.i2s_data_o    (i2s_data_o)
	);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Model and checks
	//////////////////////////////////////////////////////////////////////

	// Unsigned sums scaled to 16 bits; code 3 mixes as ACB
	function automatic audio_pkg::stereo_sample_t mix_model(
		input audio_pkg::psg_channels_t ch,
		input logic [1:0]               code
	);
		int a;
		int b;
		int c;
		int l;
		int r;
		audio_pkg::stereo_sample_t s;
		a = int'(ch.ch_a);
		b = int'(ch.ch_b);
		c = int'(ch.ch_c);
		case (code)
			2'd0: begin
				l = (a + b + c) * 4;
				r = l;
			end
			2'd1: begin
				l = (a + b) * 8;
				r = (b + c) * 8;
			end
			default: begin
				l = (a + c) * 8;
				r = (b + c) * 8;
			end
		endcase
		s.left  = SW'(l);
		s.right = SW'(r);
		return s;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at time %0t: %s: got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic compare_frame(input logic [SW-1:0] left_word,
		input logic [SW-1:0] right_word);
		audio_pkg::stereo_sample_t expected;
		if (exp_q.size() == 0) begin
			error_count++;
			$display("At time %0t an I2S frame arrived with no latched frame to compare",
				$time);
		end else begin
			expected = exp_q.pop_front();
			check_value("I2S left word with sign restored",
				{~left_word[SW-1], left_word[SW-2:0]}, expected.left);
			check_value("I2S right word with sign restored",
				{~right_word[SW-1], right_word[SW-2:0]}, expected.right);
		end
		last_left_raw  = left_word;
		last_right_raw = right_word;
		frame_count++;
	endtask

	// Inputs are stable here, they change on the falling edge
	always @(posedge clk_sys) begin
		exp_hist[2] = exp_hist[1];
		exp_hist[1] = exp_hist[0];
		if (reset_i) begin
			exp_hist[0] = '0;
		end else begin
			exp_hist[0] = mix_model(psg, mode_code);
		end
	end

	// Falling lrck marks a frame latch on the edge just taken
	always @(negedge clk_sys) begin
		if (lrck_last === 1'b1 && i2s_lrck_o === 1'b0) begin
			exp_q.push_back(exp_hist[2]);
		end
		lrck_last = i2s_lrck_o;
	end

	//////////////////////////////////////////////////////////////////////
	// I2S decoder
	//////////////////////////////////////////////////////////////////////

	// An lrck change ends the word whose LSB is sampled now
	always @(posedge i2s_bck_o) begin
		word_sr   = {word_sr[SW-2:0], i2s_data_o};
		word_bits = word_bits + 1;
		if (i2s_lrck_o !== lrck_seen) begin
			if (synced) begin
				check_value("bits in I2S word", word_bits, SW);
				if (lrck_seen === 1'b0) begin
					left_raw = word_sr;
				end else begin
					compare_frame(left_raw, word_sr);
				end
			end else if (i2s_lrck_o === 1'b0) begin
				synced = 1'b1;
			end
			word_bits = 0;
		end
		lrck_seen = i2s_lrck_o;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name    = name;
		test_checks0 = check_count;
		test_errors0 = error_count;
	endtask

	task automatic finish_test();
		test_count++;
		$display("Test %0d %s: %0d checks, %0d errors", test_count, test_name,
			check_count - test_checks0, error_count - test_errors0);
	endtask

	task automatic pick_channels(output audio_pkg::psg_channels_t ch);
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = $random(seed);
		r1 = $random(seed);
		ch = {r0[11:0], r0[27:16], r1[11:0]};
	endtask

	task automatic drive_inputs(input audio_pkg::psg_channels_t ch, input logic [1:0] code);
		@(negedge clk_sys);
		psg         = ch;
		mode_code   = code;
		stereo_mode = audio_pkg::stereo_mode_t'(code);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_count + n;
		wait (frame_count >= target);
	endtask

	task automatic hold_random(input logic [1:0] code);
		audio_pkg::psg_channels_t ch;
		pick_channels(ch);
		drive_inputs(ch, code);
		wait_frames(HOLD_FRAMES);
	endtask

	// Raw words on the wire carry an inverted sign bit
	task automatic check_corner(input audio_pkg::psg_channels_t ch, input logic [1:0] code);
		audio_pkg::stereo_sample_t expected;
		drive_inputs(ch, code);
		wait_frames(HOLD_FRAMES);
		expected = mix_model(ch, code);
		check_value("raw left word", last_left_raw, expected.left ^ (1 << (SW - 1)));
		check_value("raw right word", last_right_raw, expected.right ^ (1 << (SW - 1)));
	endtask

	task automatic measure_dac_density();
		audio_pkg::psg_channels_t  ch;
		audio_pkg::stereo_sample_t expected;
		logic [31:0]               r;
		int                        ones_l;
		int                        ones_r;
		int                        diff_l;
		int                        diff_r;
		pick_channels(ch);
		r = $random(seed);
		drive_inputs(ch, r[1:0]);
		expected = mix_model(ch, r[1:0]);
		ones_l = 0;
		ones_r = 0;
		repeat (4) @(negedge clk_sys);
		repeat (DAC_WINDOW) begin
			@(negedge clk_sys);
			ones_l += (audio_l_o === 1'b1) ? 1 : 0;
			ones_r += (audio_r_o === 1'b1) ? 1 : 0;
		end
		// Within one count of V*4096/65536, i.e. of V/16
		diff_l = ones_l * 16 - int'(expected.left);
		diff_r = ones_r * 16 - int'(expected.right);
		check_value($sformatf("left DAC ones %0d for sample %0d", ones_l, expected.left),
			(diff_l >= -16 && diff_l <= 16), 1'b1);
		check_value($sformatf("right DAC ones %0d for sample %0d", ones_r, expected.right),
			(diff_r >= -16 && diff_r <= 16), 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, the run did not finish in time", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		audio_pkg::psg_channels_t ch;
		logic [31:0]              r;
		int                       offset;
		seed        = 32'hdfe9f93f;
		check_count = 0;
		error_count = 0;
		test_count  = 0;
		frame_count = 0;
		word_bits   = 0;
		word_sr     = '0;
		left_raw    = '0;
		lrck_seen   = 1'b0;
		lrck_last   = 1'b0;
		synced      = 1'b0;
		exp_hist[0] = '0;
		exp_hist[1] = '0;
		exp_hist[2] = '0;
		reset_i     = 1'b1;
		psg         = '0;
		mode_code   = 2'd0;
		stereo_mode = audio_pkg::STEREO_MONO;

		// Zero channels keep the DAC bits low through the first bit clock
		start_test("reset");
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_i = 1'b0;
		@(negedge clk_sys);
		while (i2s_bck_o !== 1'b1) begin
			check_value("outputs low after reset",
				{audio_l_o, audio_r_o, i2s_bck_o, i2s_lrck_o, i2s_data_o}, '0);
			@(negedge clk_sys);
		end
		@(negedge i2s_bck_o);
		@(negedge i2s_bck_o);
		@(negedge clk_sys);
		check_value("lrck low at first left word", i2s_lrck_o, 1'b0);
		finish_test();

		start_test("mono mix");
		repeat (MONO_TRIALS) hold_random(2'd0);
		finish_test();

		start_test("ABC, ACB and code 3 mixes");
		for (int code = 1; code < 4; code++) begin
			repeat (PAIR_TRIALS) hold_random(2'(code));
		end
		finish_test();

		start_test("sign inversion and framing");
		check_corner({12'h000, 12'h000, 12'h000}, 2'd0);
		check_corner({12'hfff, 12'hfff, 12'hfff}, 2'd0);
		check_corner({12'hfff, 12'h000, 12'hfff}, 2'd1);
		check_corner({12'h800, 12'h7ff, 12'h001}, 2'd3);
		finish_test();

		start_test("DAC density");
		repeat (DAC_TRIALS) measure_dac_density();
		finish_test();

		// Frames latched after a change are checked by the cycle model
		start_test("mid-stream change");
		repeat (CHANGE_TRIALS) begin
			offset = int'($random(seed)) & (FRAME_CYCLES - 1);
			repeat (offset) @(negedge clk_sys);
			pick_channels(ch);
			r = $random(seed);
			drive_inputs(ch, r[1:0]);
			wait_frames(2);
		end
		wait_frames(2);
		finish_test();

		$display("Summary: %0d tests, %0d checks, %0d errors",
			test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* psg_audio_out.f */
design/audio_pkg.sv
design/psg_stereo_mixer.sv
design/sigma_delta_dac.sv
design/i2s_serializer.sv
design/psg_audio_out.sv
verification/psg_audio_out_tb.sv

/* Makefile */
# Verilator build and run for the PSG audio output path.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
FILELIST   ?= psg_audio_out.f
TB_TOP     ?= psg_audio_out_tb
RTL_TOP    ?= psg_audio_out
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= TESTBENCH PASSED

RTL_SRCS := design/audio_pkg.sv \
	design/psg_stereo_mixer.sv \
	design/sigma_delta_dac.sv \
	design/i2s_serializer.sv \
	design/psg_audio_out.sv
TB_SRCS  := verification/psg_audio_out_tb.sv
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line in the output
run: build
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
